/* verif/zx_io_vectors.txt */
# op addr data expect, all hex; W write, R read, A ack, P pulse int_src=data
# I int_n level, B border, C beep high count over addr cycles
B 0000 00 00
R 2aaf 00 01
W 00fe 05 00
B 0000 00 05
W 1234 03 00
B 0000 00 03
W 00ff 07 00
B 0000 00 03
W 00fe 15 00
C 0010 00 10
W 00fe 02 00
C 0010 00 00
W 00fb 00 00
C 0100 00 00
W 00fb 40 00
C 0100 00 40
W 7ffb 80 00
C 0100 00 80
W 00fb c5 00
C 0100 00 c5
B 0000 00 02
W 2aaf 05 00
R 2aaf 00 05
P 0000 02 00
I 0000 00 01
P 0000 01 00
I 0000 00 00
W 2aaf 04 00
I 0000 00 01
W 2aaf 07 00
R 2aaf 00 07
P 0000 02 00
P 0000 04 00
I 0000 00 00
A 0000 00 fd
A 0000 00 fb
I 0000 00 01
P 0000 03 00
I 0000 00 00
A 0000 00 ff
A 0000 00 fd
I 0000 00 01

/* project.f */
design/zx_io_pkg.sv
design/z80_strobes.sv
design/zport_decode.sv
design/zint_ctrl.sv
design/zsound.sv
design/zx_io_top.sv
verif/tb_zx_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_zx_io -f project.f -Mdir obj_dir \
  && ./obj_dir/Vtb_zx_io | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* verif/tb_zx_io.sv */
`default_nettype none

module tb_zx_io import zx_io_pkg::*; ();

  logic                 fclk = 1'b0;
  logic                 arst_n;
  logic                 iorq_n;
  logic                 rd_n;
  logic                 wr_n;
  logic                 m1_n;
  logic [addr_w-1:0]    a;
  logic [data_w-1:0]    din;
  logic [n_int_src-1:0] int_src;
  wire  [data_w-1:0]    dout;
  wire                  dout_en;
  wire                  int_n;
  wire  [border_w-1:0]  border;
  wire                  beep;

  int     errors   = 0;
  int     checks   = 0;
  int     timeouts = 0;
  integer seed     = 32'h6bb6;

  always #10 fclk = ~fclk;

  zx_io_top u_zx_io_top (
    .fclk    (fclk),
    .arst_n  (arst_n),
    .iorq_n  (iorq_n),
    .rd_n    (rd_n),
    .wr_n    (wr_n),
    .m1_n    (m1_n),
    .a       (a),
    .din     (din),
    .int_src (int_src),
    .dout    (dout),
    .dout_en (dout_en),
    .int_n   (int_n),
    .border  (border),
    .beep    (beep)
  );

  task automatic check_no_drive();
    checks++;
    assert (dout_en == 1'b0) else begin
      errors++;
      $display("Error: dout_en = %h, expected %h", dout_en, 1'b0);
    end
  endtask

  // bus held 8 cycles in total and then 2 idle
  task automatic end_cycle(input int held);
    if (held < 8) repeat (8 - held) @(negedge fclk);
    @(posedge fclk);
    iorq_n <= 1'b1;
    rd_n   <= 1'b1;
    wr_n   <= 1'b1;
    m1_n   <= 1'b1;
    repeat (2) @(posedge fclk);
  endtask

  task automatic io_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
    @(posedge fclk);
    a      <= addr;
    din    <= data;
    iorq_n <= 1'b0;
    wr_n   <= 1'b0;
    repeat (8) begin
      @(negedge fclk);
      check_no_drive();  // writes never drive the bus
    end
    end_cycle(8);
  endtask

  // read or acknowledge already started so wait for the drive and check it
  task automatic read_back(input logic [data_w-1:0] exp, input string what);
    int cycles;
    bit seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 20) begin
      @(negedge fclk);
      cycles++;
      seen = dout_en;
    end
    if (!seen) begin
      timeouts++;
      $display("timeout: dout_en never went high during the %s", what);
    end else begin
      checks++;
      assert (dout == exp) else begin
        errors++;
        $display("Error: dout = %h, expected %h (%s)", dout, exp, what);
      end
      // the data has to hold until the bus cycle ends
      while (cycles < 8) begin
        @(negedge fclk);
        cycles++;
        checks++;
        assert (dout_en && dout == exp) else begin
          errors++;
          $display("Error: dout_en = %h dout = %h, expected 1 and %h (%s)",
                   dout_en, dout, exp, what);
        end
      end
    end
    end_cycle(cycles);
  endtask

  task automatic expect_int_n(input logic lvl);
    int  cycles;
    bit  seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < 20) begin
      @(negedge fclk);
      cycles++;
      seen = (int_n == lvl);
    end
    if (!seen) begin
      timeouts++;
      $display("timeout: int_n did not reach the expected level");
    end
    repeat (4) begin  // and it has to stay there
      @(negedge fclk);
      checks++;
      assert (int_n == lvl) else begin
        errors++;
        $display("Error: int_n = %h, expected %h", int_n, lvl);
      end
    end
  endtask

  task automatic count_beep(input int len, input int exp);
    int hi;
    hi = 0;
    repeat (len) begin
      @(negedge fclk);
      if (beep) hi++;
    end
    checks++;
    assert (hi == exp) else begin
      errors++;
      $display("Error: beep high count = %h, expected %h", hi, exp);
    end
  endtask

  task automatic idle_gap();
    int gap;
    gap = $unsigned($random(seed)) % 4;
    repeat (gap) begin
      @(negedge fclk);
      check_no_drive();
    end
  endtask

  initial begin
    string             line;
    int                fd;
    int                n;
    logic [7:0]        op;
    logic [15:0]       v_addr;
    logic [15:0]       v_data;
    logic [15:0]       v_exp;
    arst_n  = 1'b0;
    iorq_n  = 1'b1;
    rd_n    = 1'b1;
    wr_n    = 1'b1;
    m1_n    = 1'b1;
    a       = '0;
    din     = '0;
    int_src = '0;
    repeat (2) @(posedge fclk);
    arst_n <= 1'b1;
    fd = $fopen("verif/zx_io_vectors.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the vector file verif/zx_io_vectors.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 2 && line.getc(0) != "#") begin
          op = line.getc(0);
          n  = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", v_addr, v_data, v_exp);
          if (n != 3) begin
            errors++;
            $display("malformed line in the vector file: %s", line);
          end else begin
            case (op)
              "W": io_write(v_addr, v_data[7:0]);
              "R": begin
                @(posedge fclk);
                a      <= v_addr;
                iorq_n <= 1'b0;
                rd_n   <= 1'b0;
                read_back(v_exp[7:0], "port read");
              end
              "A": begin
                @(posedge fclk);
                iorq_n <= 1'b0;
                m1_n   <= 1'b0;
                read_back(v_exp[7:0], "interrupt acknowledge");
              end
              "P": begin  // one cycle source pulse
                @(posedge fclk);
                int_src <= v_data[n_int_src-1:0];
                @(posedge fclk);
                int_src <= '0;
              end
              "I": expect_int_n(v_exp[0]);
              "B": begin
                @(negedge fclk);
                checks++;
                assert (border == v_exp[border_w-1:0]) else begin
                  errors++;
                  $display("Error: border = %h, expected %h", border, v_exp[border_w-1:0]);
                end
              end
              "C": count_beep(int'(v_addr), int'(v_exp));
              default: begin
                errors++;
                $display("unknown operation %c in the vector file", op);
              end
            endcase
          end
          idle_gap();
        end
      end
      $fclose(fd);
    end
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* design/zx_io_top.sv */
`default_nettype none

module zx_io_top import zx_io_pkg::*; (
  input  wire                  fclk,
  input  wire                  arst_n,
  input  wire                  iorq_n,
  input  wire                  rd_n,
  input  wire                  wr_n,
  input  wire                  m1_n,
  input  wire [addr_w-1:0]     a,
  input  wire [data_w-1:0]     din,
  input  wire [n_int_src-1:0]  int_src,
  output logic [data_w-1:0]    dout,
  output logic                 dout_en,
  output logic                 int_n,
  output logic [border_w-1:0]  border,
  output logic                 beep
);

  wire                 iowr_s;
  wire                 iord;
  wire                 intack;
  wire                 intack_s;
  wire                 fe_we;
  wire                 covox_we;
  wire                 intmask_we;
  wire                 int_ack;
  wire [n_int_src-1:0] intmask;
  wire [data_w-1:0]    im2vect;

  z80_strobes u_strobes (
    .fclk     (fclk),
    .arst_n   (arst_n),
    .iorq_n   (iorq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .m1_n     (m1_n),
    .iowr_s   (iowr_s),
    .iord     (iord),
    .intack   (intack),
    .intack_s (intack_s)
  );

  zport_decode u_decode (
    .fclk       (fclk),
    .arst_n     (arst_n),
    .a          (a),
    .din        (din),
    .iowr_s     (iowr_s),
    .iord       (iord),
    .intack     (intack),
    .intack_s   (intack_s),
    .intmask    (intmask),
    .im2vect    (im2vect),
    .fe_we      (fe_we),
    .covox_we   (covox_we),
    .intmask_we (intmask_we),
    .int_ack    (int_ack),
    .dout       (dout),
    .dout_en    (dout_en)
  );

  zint_ctrl u_int (
    .fclk       (fclk),
    .arst_n     (arst_n),
    .din        (din),
    .intmask_we (intmask_we),
    .int_ack    (int_ack),
    .int_src    (int_src),
    .intmask    (intmask),
    .im2vect    (im2vect),
    .int_n      (int_n)
  );

  zsound u_sound (
    .fclk     (fclk),
    .arst_n   (arst_n),
    .din      (din),
    .fe_we    (fe_we),
    .covox_we (covox_we),
    .border   (border),
    .beep     (beep)
  );

endmodule

`default_nettype wire

/* design/zsound.sv */
`default_nettype none

module zsound import zx_io_pkg::*; (
  input  wire                 fclk,
  input  wire                 arst_n,
  input  wire [data_w-1:0]    din,
  input  wire                 fe_we,
  input  wire                 covox_we,
  output logic [border_w-1:0] border,
  output logic                beep
);

  zx_wr_byte_u wr_byte;

  logic              beeper;
  logic              covox_sel;  // 1 when the last sound write was covox
  logic [data_w-1:0] sample;
  logic [data_w-1:0] acc;
  logic              covox_bit;

  assign wr_byte = din;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      border    <= '0;
      beeper    <= 1'b0;
      covox_sel <= 1'b0;
      acc       <= '0;
      covox_bit <= 1'b0;
    end else begin
      if (fe_we) begin
        border    <= wr_byte.ula.border;
        beeper    <= wr_byte.ula.beeper;
        covox_sel <= 1'b0;
      end else if (covox_we) begin
        covox_sel <= 1'b1;
      end
      // first order sigma-delta, carry out is the pdm bit
      if (covox_sel) begin
        {covox_bit, acc} <= {1'b0, acc} + {1'b0, sample};
      end
    end
  end

  always_ff @(posedge fclk) begin
    if (covox_we) begin
      sample <= wr_byte.raw;
    end
  end

  assign beep = covox_sel ? covox_bit : beeper;

endmodule

`default_nettype wire

/* design/zint_ctrl.sv */
`default_nettype none

module zint_ctrl import zx_io_pkg::*; (
  input  wire                  fclk,
  input  wire                  arst_n,
  input  wire [data_w-1:0]     din,
  input  wire                  intmask_we,
  input  wire                  int_ack,
  input  wire [n_int_src-1:0]  int_src,
  output logic [n_int_src-1:0] intmask,
  output logic [data_w-1:0]    im2vect,
  output logic                 int_n
);

  logic [n_int_src-1:0] pending;
  logic [n_int_src-1:0] pend_top;   // one-hot highest priority pending
  logic [n_int_src-1:0] pend_clr;
  logic [n_int_src-1:0] pend_nxt;

  // lowest bit wins so frame goes first
  assign pend_top = pending & (~pending + 1'b1);

  always_comb begin
    im2vect = vec_frm;  // frame or nothing pending
    if (pend_top[1]) begin
      im2vect = vec_lin;
    end else if (pend_top[2]) begin
      im2vect = vec_dma;
    end
  end

  assign pend_clr = int_ack ? pend_top : '0;

  always_comb begin
    pend_nxt = (pending & ~pend_clr) | (int_src & intmask);
    if (intmask_we) begin
      pend_nxt = pend_nxt & din[n_int_src-1:0];  // masking drops the request too
    end
  end

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      intmask <= intmask_rst;
      pending <= '0;
      int_n   <= 1'b1;
    end else begin
      if (intmask_we) begin
        intmask <= din[n_int_src-1:0];
      end
      pending <= pend_nxt;
      int_n   <= ~|pending;  // one cycle behind the flags
    end
  end

  // flags only clear through an ack or a mask write
  a_int_idle: assert property (@(posedge fclk) disable iff (!arst_n)
    !(|pending) && !$past(int_ack) && !$past(intmask_we) |-> int_n)
    else $error("int_n low with no pending source");

endmodule

`default_nettype wire

/* design/zport_decode.sv */
`default_nettype none

module zport_decode import zx_io_pkg::*; (
  input  wire                  fclk,
  input  wire                  arst_n,
  input  wire [addr_w-1:0]     a,
  input  wire [data_w-1:0]     din,
  input  wire                  iowr_s,
  input  wire                  iord,
  input  wire                  intack,
  input  wire                  intack_s,
  input  wire [n_int_src-1:0]  intmask,
  input  wire [data_w-1:0]     im2vect,
  output logic                 fe_we,
  output logic                 covox_we,
  output logic                 intmask_we,
  output logic                 int_ack,
  output logic [data_w-1:0]    dout,
  output logic                 dout_en
);

  logic ula_hit;
  logic covox_hit;
  logic intmask_hit;

  logic [data_w-1:0] vect_q;  // vector seen at the start of acknowledge

  // Spectrum style partial decode for the ULA, the others need more bits
  assign ula_hit     = ~a[fe_sel_bit];
  assign covox_hit   = a[7:0] == port_covox;
  assign intmask_hit = a == port_intmask;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      fe_we      <= 1'b0;
      covox_we   <= 1'b0;
      intmask_we <= 1'b0;
    end else begin
      fe_we      <= iowr_s & ula_hit;
      covox_we   <= iowr_s & covox_hit;
      intmask_we <= iowr_s & intmask_hit;
    end
  end

  // zint_ctrl moves on to the next source right after the ack,
  // so keep the served vector for the rest of the bus cycle
  always_ff @(posedge fclk) begin
    if (intack_s) begin
      vect_q <= im2vect;
    end
  end

  assign int_ack = intack_s;

  always_comb begin
    dout_en = 1'b0;
    dout    = '0;
    if (intack) begin
      dout_en = 1'b1;
      dout    = intack_s ? im2vect : vect_q;
    end else if (iord && intmask_hit) begin
      dout_en = 1'b1;
      dout    = data_w'(intmask);  // upper bits read as zero
    end
  end

  a_we_onehot: assert property (@(posedge fclk) disable iff (!arst_n)
    $onehot0({fe_we, covox_we, intmask_we}))
    else $error("more than one port write enable active");

  // write data is taken one cycle after the strobe
  a_din_stable: assert property (@(posedge fclk) disable iff (!arst_n)
    iowr_s |=> $stable(din) && $stable(a))
    else $error("bus changed between write strobe and write enable");

endmodule

`default_nettype wire

/* design/z80_strobes.sv */
`default_nettype none

module z80_strobes (
  input  wire  fclk,
  input  wire  arst_n,
  input  wire  iorq_n,
  input  wire  rd_n,
  input  wire  wr_n,
  input  wire  m1_n,
  output logic iowr_s,
  output logic iord,
  output logic intack,
  output logic intack_s
);

  // two-stage synchronizers, active high inside
  logic [1:0] iorq_sy;
  logic [1:0] rd_sy;
  logic [1:0] wr_sy;
  logic [1:0] m1_sy;

  logic iowr;
  logic iowr_d;
  logic intack_d;

  always_ff @(posedge fclk or negedge arst_n) begin
    if (!arst_n) begin
      iorq_sy  <= '0;
      rd_sy    <= '0;
      wr_sy    <= '0;
      m1_sy    <= '0;
      iowr_d   <= 1'b0;
      intack_d <= 1'b0;
    end else begin
      iorq_sy  <= {iorq_sy[0], ~iorq_n};
      rd_sy    <= {rd_sy[0], ~rd_n};
      wr_sy    <= {wr_sy[0], ~wr_n};
      m1_sy    <= {m1_sy[0], ~m1_n};
      iowr_d   <= iowr;
      intack_d <= intack;
    end
  end

  assign iowr   = iorq_sy[1] & wr_sy[1];
  assign iord   = iorq_sy[1] & rd_sy[1];
  assign intack = iorq_sy[1] & m1_sy[1];  // iorq with m1 is an int acknowledge

  // rising edges
  assign iowr_s   = iowr & ~iowr_d;
  assign intack_s = intack & ~intack_d;

  a_wr_not_ack: assert property (@(posedge fclk) disable iff (!arst_n)
    !(iowr_s && intack_s))
    else $error("iowr_s and intack_s high in the same cycle");

endmodule

`default_nettype wire

/* design/zx_io_pkg.sv */
`default_nettype none

package zx_io_pkg;

  localparam int addr_w = 16, data_w = 8;

  localparam int border_w = 3;

  // covox decodes the low address byte only
  localparam logic [7:0] port_covox = 8'hFB;

  localparam logic [addr_w-1:0] port_intmask = 16'h2AAF;

  // ULA port answers when this address bit is zero
  localparam int fe_sel_bit = 0;

  // IM2 vectors
  localparam logic [data_w-1:0] vec_frm = 8'hFF;
  localparam logic [data_w-1:0] vec_lin = 8'hFD;
  localparam logic [data_w-1:0] vec_dma = 8'hFB;

  // bit 0 frame, bit 1 line, bit 2 dma
  localparam int n_int_src = 3;

  localparam logic [n_int_src-1:0] intmask_rst = 3'b001;  // frame only

  typedef struct packed {
    logic [2:0]          unused;
    logic                beeper;
    logic                tape_out;
    logic [border_w-1:0] border;
  } zx_ula_byte_t;

  // the byte on a port write, seen as ULA fields or as a covox sample
  typedef union packed {
    zx_ula_byte_t      ula;
    logic [data_w-1:0] raw;
  } zx_wr_byte_u;

endpackage

`default_nettype wire
